/* source/sc_pkg.sv */
package sc_pkg;

   // signed I and Q input samples
   localparam int SAMPLE_WIDTH = 16;

   // autocorrelation lag in samples
   localparam int DELAY_LEN = 16;

   // drop this many fraction bits from each full product
   localparam int PROD_SHIFT = 8;

   // correlation and power terms after the shift
   localparam int PROD_WIDTH = 25;

   // moving sum window
   localparam int WINDOW_LEN = 32;
   localparam int WINDOW_LOG2 = 5;

   // sum growth covers the whole window
   localparam int SUM_WIDTH = PROD_WIDTH + WINDOW_LOG2;

   // detect when |P|^2 > R^2 * THRESH_NUM / 2^THRESH_SHIFT
   localparam int THRESH_NUM = 3;
   localparam int THRESH_SHIFT = 2;

endpackage

/* source/sc_front_end.sv */
`timescale 1ns/10ps

module sc_front_end (
   input  logic                                    clk,
   input  logic                                    i_reset,
   input  logic                                    i_clear,
   input  logic signed [sc_pkg::SAMPLE_WIDTH-1:0]  i_i,
   input  logic signed [sc_pkg::SAMPLE_WIDTH-1:0]  i_q,
   input  logic                                    i_tlast,
   input  logic                                    i_tvalid,
   input  logic                                    i_ready_down,
   output logic                                    o_tready,
   output logic signed [sc_pkg::PROD_WIDTH-1:0]    o_corr_i,
   output logic signed [sc_pkg::PROD_WIDTH-1:0]    o_corr_q,
   output logic [sc_pkg::PROD_WIDTH-1:0]           o_pow,
   output logic                                    o_last,
   output logic                                    o_valid
);
   import sc_pkg::*;

   // past samples with the newest at index 0
   logic signed [SAMPLE_WIDTH-1:0] dline_i [DELAY_LEN];
   logic signed [SAMPLE_WIDTH-1:0] dline_q [DELAY_LEN];

   logic signed [SAMPLE_WIDTH-1:0] s1_i;
   logic signed [SAMPLE_WIDTH-1:0] s1_q;
   logic signed [SAMPLE_WIDTH-1:0] s1_di;
   logic signed [SAMPLE_WIDTH-1:0] s1_dq;
   logic                           s1_last;
   logic                           s1_valid;

   logic s1_ready;
   logic s2_ready;
   logic in_fire;

   logic signed [2*SAMPLE_WIDTH-1:0] m_ii;
   logic signed [2*SAMPLE_WIDTH-1:0] m_qq;
   logic signed [2*SAMPLE_WIDTH-1:0] m_qi;
   logic signed [2*SAMPLE_WIDTH-1:0] m_iq;
   logic signed [2*SAMPLE_WIDTH-1:0] sq_i;
   logic signed [2*SAMPLE_WIDTH-1:0] sq_q;
   logic signed [2*SAMPLE_WIDTH:0]   full_re;
   logic signed [2*SAMPLE_WIDTH:0]   full_im;
   logic signed [2*SAMPLE_WIDTH:0]   full_pow;
   logic signed [2*SAMPLE_WIDTH:0]   sh_re;
   logic signed [2*SAMPLE_WIDTH:0]   sh_im;
   logic signed [2*SAMPLE_WIDTH:0]   sh_pow;

   // each register stage takes a new item when empty or when draining
   assign s2_ready = !o_valid || i_ready_down;
   assign s1_ready = !s1_valid || s2_ready;
   assign o_tready = s1_ready;
   assign in_fire  = i_tvalid && s1_ready;

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         for (int k = 0; k < DELAY_LEN; k++) begin
            dline_i[k] <= '0;
            dline_q[k] <= '0;
         end
      end else if (in_fire) begin
         dline_i[0] <= i_i;
         dline_q[0] <= i_q;
         for (int k = 1; k < DELAY_LEN; k++) begin
            dline_i[k] <= dline_i[k-1];
            dline_q[k] <= dline_q[k-1];
         end
      end
   end

   // stage one pairs x[n] with x[n-16]
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         s1_valid <= 1'b0;
      end else if (s1_ready) begin
         s1_valid <= i_tvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         s1_i    <= i_i;
         s1_q    <= i_q;
         s1_di   <= dline_i[DELAY_LEN-1];
         s1_dq   <= dline_q[DELAY_LEN-1];
         s1_last <= i_tlast;
      end
   end

   // x * conj(d) = (xi*di + xq*dq) + j(xq*di - xi*dq)
   always_comb begin
      m_ii     = s1_i * s1_di;
      m_qq     = s1_q * s1_dq;
      m_qi     = s1_q * s1_di;
      m_iq     = s1_i * s1_dq;
      sq_i     = s1_i * s1_i;
      sq_q     = s1_q * s1_q;
      full_re  = m_ii + m_qq;
      full_im  = m_qi - m_iq;
      full_pow = sq_i + sq_q;
      sh_re    = full_re >>> PROD_SHIFT;
      sh_im    = full_im >>> PROD_SHIFT;
      sh_pow   = full_pow >>> PROD_SHIFT;
   end

   // stage two holds the scaled products
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         o_valid <= 1'b0;
      end else if (s2_ready) begin
         o_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid && s2_ready) begin
         o_corr_i <= sh_re[PROD_WIDTH-1:0];
         o_corr_q <= sh_im[PROD_WIDTH-1:0];
         o_pow    <= sh_pow[PROD_WIDTH-1:0];
         o_last   <= s1_last;
      end
   end

endmodule

/* source/sc_moving_sum.sv */
`timescale 1ns/10ps

module sc_moving_sum #(
   parameter int WIDTH = sc_pkg::PROD_WIDTH
) (
   input  logic                                 clk,
   input  logic                                 i_reset,
   input  logic                                 i_clear,
   input  logic signed [WIDTH-1:0]              i_data,
   input  logic                                 i_last,
   input  logic                                 i_valid,
   input  logic                                 i_ready_down,
   output logic                                 o_ready,
   output logic signed [sc_pkg::SUM_WIDTH-1:0]  o_sum,
   output logic                                 o_last,
   output logic                                 o_valid
);
   import sc_pkg::*;

   logic signed [WIDTH-1:0] hist [WINDOW_LEN];
   logic [WINDOW_LOG2-1:0]  wr_ptr;
   logic                    full;
   logic signed [WIDTH-1:0] leaving;
   logic                    in_fire;

   assign o_ready = !o_valid || i_ready_down;
   assign in_fire = i_valid && o_ready;

   // slots not written since the last clear count as zero
   assign leaving = full ? hist[wr_ptr] : '0;

   // o_sum is the running accumulator itself
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         wr_ptr  <= '0;
         full    <= 1'b0;
         o_sum   <= '0;
         o_valid <= 1'b0;
      end else begin
         if (o_ready) begin
            o_valid <= i_valid;
         end
         if (in_fire) begin
            o_sum  <= o_sum + i_data - leaving;
            wr_ptr <= wr_ptr + 1'b1;
            // window is filled once the pointer wraps
            if (wr_ptr == WINDOW_LOG2'(WINDOW_LEN - 1)) begin
               full <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         hist[wr_ptr] <= i_data;
         o_last       <= i_last;
      end
   end

endmodule

/* source/sc_threshold.sv */
`timescale 1ns/10ps

module sc_threshold (
   input  logic                                 clk,
   input  logic                                 i_reset,
   input  logic                                 i_clear,
   input  logic signed [sc_pkg::SUM_WIDTH-1:0]  i_p_i,
   input  logic signed [sc_pkg::SUM_WIDTH-1:0]  i_p_q,
   input  logic signed [sc_pkg::SUM_WIDTH-1:0]  i_r,
   input  logic                                 i_last,
   input  logic                                 i_valid,
   input  logic                                 i_tready,
   output logic                                 o_ready,
   output logic                                 o_detect,
   output logic                                 o_tlast,
   output logic                                 o_tvalid
);
   import sc_pkg::*;

   logic signed [2*SUM_WIDTH-1:0] pi_prod;
   logic signed [2*SUM_WIDTH-1:0] pq_prod;
   logic signed [2*SUM_WIDTH-1:0] r_prod;

   // squares are never negative, so they are kept unsigned
   logic [2*SUM_WIDTH-1:0] pi_sq;
   logic [2*SUM_WIDTH-1:0] pq_sq;
   logic [2*SUM_WIDTH-1:0] r_sq;
   logic                   s1_last;
   logic                   s1_valid;

   logic        s2_ready;
   logic        in_fire;
   logic [63:0] p_mag;
   logic [63:0] r_scaled;

   assign s2_ready = !o_tvalid || i_tready;
   assign o_ready  = !s1_valid || s2_ready;
   assign in_fire  = i_valid && o_ready;

   assign pi_prod = i_p_i * i_p_i;
   assign pq_prod = i_p_q * i_p_q;
   assign r_prod  = i_r * i_r;

   // stage one registers the three squares
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         s1_valid <= 1'b0;
      end else if (o_ready) begin
         s1_valid <= i_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         pi_sq   <= pi_prod;
         pq_sq   <= pq_prod;
         r_sq    <= r_prod;
         s1_last <= i_last;
      end
   end

   // |P|^2 against R^2 * 3/4
   assign p_mag    = 64'(pi_sq) + 64'(pq_sq);
   assign r_scaled = (64'(r_sq) * 64'(THRESH_NUM)) >> THRESH_SHIFT;

   // stage two makes the decision; strictly greater keeps all-zero input low
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         o_tvalid <= 1'b0;
      end else if (s2_ready) begin
         o_tvalid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid && s2_ready) begin
         o_detect <= (p_mag > r_scaled);
         o_tlast  <= s1_last;
      end
   end

endmodule

/* source/schmidl_cox.sv */
`timescale 1ns/10ps

module schmidl_cox (
   input  logic                                    clk,
   input  logic                                    i_reset,
   input  logic                                    i_clear,
   input  logic signed [sc_pkg::SAMPLE_WIDTH-1:0]  i_i,
   input  logic signed [sc_pkg::SAMPLE_WIDTH-1:0]  i_q,
   input  logic                                    i_tlast,
   input  logic                                    i_tvalid,
   input  logic                                    i_tready,
   output logic                                    o_tready,
   output logic                                    o_detect,
   output logic                                    o_tlast,
   output logic                                    o_tvalid
);
   import sc_pkg::*;

   logic signed [PROD_WIDTH-1:0] fe_corr_i;
   logic signed [PROD_WIDTH-1:0] fe_corr_q;
   logic [PROD_WIDTH-1:0]        fe_pow;
   logic                         fe_last;
   logic                         fe_valid;
   logic                         fe_ready;

   logic                         ci_ready;
   logic                         cq_ready;
   logic                         pw_ready;
   logic signed [SUM_WIDTH-1:0]  sum_ci;
   logic signed [SUM_WIDTH-1:0]  sum_cq;
   logic signed [SUM_WIDTH-1:0]  sum_pw;
   logic                         ms_last;
   logic                         ms_valid;
   logic                         th_ready;

   // the three sums step in lockstep, so one valid and last serve all
   assign fe_ready = ci_ready && cq_ready && pw_ready;

   sc_front_end front_end_i (
      .clk(clk), .i_reset(i_reset), .i_clear(i_clear),
      .i_i(i_i), .i_q(i_q), .i_tlast(i_tlast), .i_tvalid(i_tvalid),
      .i_ready_down(fe_ready), .o_tready(o_tready),
      .o_corr_i(fe_corr_i), .o_corr_q(fe_corr_q), .o_pow(fe_pow),
      .o_last(fe_last), .o_valid(fe_valid));

   // real part of P
   sc_moving_sum #(.WIDTH(PROD_WIDTH)) sum_corr_i (
      .clk(clk), .i_reset(i_reset), .i_clear(i_clear),
      .i_data(fe_corr_i), .i_last(fe_last), .i_valid(fe_valid),
      .i_ready_down(th_ready), .o_ready(ci_ready),
      .o_sum(sum_ci), .o_last(ms_last), .o_valid(ms_valid));

   // imaginary part of P
   sc_moving_sum #(.WIDTH(PROD_WIDTH)) sum_corr_q (
      .clk(clk), .i_reset(i_reset), .i_clear(i_clear),
      .i_data(fe_corr_q), .i_last(fe_last), .i_valid(fe_valid),
      .i_ready_down(th_ready), .o_ready(cq_ready),
      .o_sum(sum_cq), .o_last(), .o_valid());

   // R
   sc_moving_sum #(.WIDTH(PROD_WIDTH)) sum_pow (
      .clk(clk), .i_reset(i_reset), .i_clear(i_clear),
      .i_data($signed(fe_pow)), .i_last(fe_last), .i_valid(fe_valid),
      .i_ready_down(th_ready), .o_ready(pw_ready),
      .o_sum(sum_pw), .o_last(), .o_valid());

   sc_threshold threshold_i (
      .clk(clk), .i_reset(i_reset), .i_clear(i_clear),
      .i_p_i(sum_ci), .i_p_q(sum_cq), .i_r(sum_pw),
      .i_last(ms_last), .i_valid(ms_valid), .i_tready(i_tready),
      .o_ready(th_ready), .o_detect(o_detect),
      .o_tlast(o_tlast), .o_tvalid(o_tvalid));

endmodule

/* tb/tb_schmidl_cox.sv */
`timescale 1ns/10ps

module tb_schmidl_cox;
   import sc_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int LATENCY_NS = 5 * CLK_PERIOD;
   localparam int WAIT_LIMIT = 1000;

   // segment kinds
   localparam int KIND_NOISE    = 0;
   localparam int KIND_PREAMBLE = 1;
   localparam int KIND_ZERO     = 2;

   // table columns
   localparam int COL_KIND  = 0;
   localparam int COL_LEN   = 1;
   localparam int COL_AMP   = 2;
   localparam int COL_BP    = 3;
   localparam int COL_CLEAR = 4;
   localparam int NUM_SEGS  = 6;

   // kind, length, amplitude, random back-pressure, clear before the segment
   int seg_table [NUM_SEGS][5] = '{
      '{KIND_NOISE,    64,   200, 0, 0},
      '{KIND_PREAMBLE, 96,  8000, 0, 0},
      '{KIND_ZERO,     48,     0, 0, 1},
      '{KIND_NOISE,    96,  3000, 1, 0},
      '{KIND_PREAMBLE, 80, 12000, 1, 0},
      '{KIND_PREAMBLE, 64,  5000, 0, 1}
   };

   string seg_name [NUM_SEGS] = '{
      "noise, small amplitude",
      "repeated preamble",
      "all-zero input after clear",
      "noise with back-pressure",
      "preamble with back-pressure",
      "preamble after mid-stream clear"
   };

   logic                           clk;
   logic                           i_reset;
   logic                           i_clear;
   logic signed [SAMPLE_WIDTH-1:0] i_i;
   logic signed [SAMPLE_WIDTH-1:0] i_q;
   logic                           i_tlast;
   logic                           i_tvalid;
   logic                           i_tready;
   logic                           o_tready;
   logic                           o_detect;
   logic                           o_tlast;
   logic                           o_tvalid;

   integer seed = 32'he1c;
   int     errors;
   int     tests_passed;
   int     tests_failed;
   int     pre_hits;
   int     outputs_seen;
   bit     cur_bp;
   bit     timed_out;
   string  timeout_what;

   // reference model state
   longint dly_i [DELAY_LEN];
   longint dly_q [DELAY_LEN];
   longint win_ci [WINDOW_LEN];
   longint win_cq [WINDOW_LEN];
   longint win_pw [WINDOW_LEN];
   int     win_pos;
   int     pat_i [DELAY_LEN];
   int     pat_q [DELAY_LEN];

   // expected items in input order
   bit  exp_detect [$];
   bit  exp_last [$];
   time exp_time [$];
   bit  exp_timed [$];
   bit  exp_zero [$];
   bit  exp_pre [$];

   schmidl_cox schmidl_cox_i (
      .clk(clk),
      .i_reset(i_reset),
      .i_clear(i_clear),
      .i_i(i_i),
      .i_q(i_q),
      .i_tlast(i_tlast),
      .i_tvalid(i_tvalid),
      .i_tready(i_tready),
      .o_tready(o_tready),
      .o_detect(o_detect),
      .o_tlast(o_tlast),
      .o_tvalid(o_tvalid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      if (cur_bp) begin
         i_tready <= (($random(seed) & 3) != 0);
      end else begin
         i_tready <= 1'b1;
      end
   end

   task automatic check_value(input string what, input longint got, input longint exp);
      if (got != exp) begin
         $display("ERR at %0d ns: %s mismatch, got %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic int rand_component(input int amp);
      return $random(seed) % (amp + 1);
   endfunction

   task automatic reset_model();
      int k;
      for (k = 0; k < DELAY_LEN; k++) begin
         dly_i[k] = 0;
         dly_q[k] = 0;
      end
      for (k = 0; k < WINDOW_LEN; k++) begin
         win_ci[k] = 0;
         win_cq[k] = 0;
         win_pw[k] = 0;
      end
      win_pos = 0;
   endtask

   // x[n] * conj(x[n-16]) and |x[n]|^2 summed over the last 32 samples
   task automatic model_accept(input int si, input int sq, input bit sl);
      longint xi;
      longint xq;
      longint di;
      longint dq;
      longint p_i;
      longint p_q;
      longint r;
      longint p_mag;
      longint r_scaled;
      int     k;
      xi = si;
      xq = sq;
      di = dly_i[DELAY_LEN-1];
      dq = dly_q[DELAY_LEN-1];
      for (k = DELAY_LEN - 1; k > 0; k--) begin
         dly_i[k] = dly_i[k-1];
         dly_q[k] = dly_q[k-1];
      end
      dly_i[0] = xi;
      dly_q[0] = xq;
      win_ci[win_pos] = (xi * di + xq * dq) >>> PROD_SHIFT;
      win_cq[win_pos] = (xq * di - xi * dq) >>> PROD_SHIFT;
      win_pw[win_pos] = (xi * xi + xq * xq) >>> PROD_SHIFT;
      win_pos = (win_pos + 1) % WINDOW_LEN;
      p_i = 0;
      p_q = 0;
      r = 0;
      for (k = 0; k < WINDOW_LEN; k++) begin
         p_i += win_ci[k];
         p_q += win_cq[k];
         r += win_pw[k];
      end
      p_mag = p_i * p_i + p_q * p_q;
      r_scaled = (r * r * THRESH_NUM) >> THRESH_SHIFT;
      exp_detect.push_back(p_mag > r_scaled);
      exp_last.push_back(sl);
   endtask

   // starts just after a rising edge and returns on the edge that takes the sample
   task automatic drive_sample(input int si, input int sq, input bit sl, input bit timed,
                               input bit zero_in, input bit pre_in, output bit ok);
      int waited;
      i_i <= SAMPLE_WIDTH'(si);
      i_q <= SAMPLE_WIDTH'(sq);
      i_tlast <= sl;
      i_tvalid <= 1'b1;
      waited = 0;
      ok = 1'b1;
      @(posedge clk);
      while (!o_tready && ok) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            ok = 1'b0;
            timeout_what = "input handshake";
         end else begin
            @(posedge clk);
         end
      end
      if (ok) begin
         model_accept(si, sq, sl);
         exp_time.push_back($time);
         exp_timed.push_back(timed);
         exp_zero.push_back(zero_in);
         exp_pre.push_back(pre_in);
      end
   endtask

   task automatic wait_drain(output bit ok);
      int waited;
      waited = 0;
      ok = 1'b1;
      while (exp_detect.size() != 0 && ok) begin
         waited++;
         if (waited > WAIT_LIMIT) begin
            ok = 1'b0;
            timeout_what = "output for every accepted sample";
         end else begin
            @(posedge clk);
         end
      end
   endtask

   task automatic pulse_clear();
      i_clear <= 1'b1;
      @(posedge clk);
      i_clear <= 1'b0;
      reset_model();
   endtask

   task automatic run_segment(input int s);
      int n;
      int si;
      int sq;
      int kind;
      int amp;
      bit sl;
      bit ok;
      kind = seg_table[s][COL_KIND];
      amp = seg_table[s][COL_AMP];
      cur_bp = seg_table[s][COL_BP] != 0;
      pre_hits = 0;
      outputs_seen = 0;
      if (seg_table[s][COL_CLEAR] != 0) begin
         pulse_clear();
      end
      for (n = 0; n < DELAY_LEN; n++) begin
         pat_i[n] = rand_component(amp);
         pat_q[n] = rand_component(amp);
      end
      @(posedge clk);
      ok = 1'b1;
      for (n = 0; n < seg_table[s][COL_LEN] && ok; n++) begin
         case (kind)
            KIND_NOISE: begin
               si = rand_component(amp);
               sq = rand_component(amp);
            end
            KIND_PREAMBLE: begin
               si = pat_i[n % DELAY_LEN];
               sq = pat_q[n % DELAY_LEN];
            end
            default: begin
               si = 0;
               sq = 0;
            end
         endcase
         sl = (n % 16 == 15) || (n == seg_table[s][COL_LEN] - 1);
         // idle gaps on the input side as well
         if (cur_bp && (($random(seed) & 7) == 0)) begin
            i_tvalid <= 1'b0;
            @(posedge clk);
         end
         drive_sample(si, sq, sl, !cur_bp, kind == KIND_ZERO, kind == KIND_PREAMBLE, ok);
      end
      i_tvalid <= 1'b0;
      i_tlast <= 1'b0;
      if (ok) begin
         wait_drain(ok);
      end
      if (!ok) begin
         timed_out = 1'b1;
      end else if (kind == KIND_PREAMBLE) begin
         check_value("preamble detect seen", longint'(pre_hits > 0), 1);
      end
   endtask

   // output side is compared on every handshake
   always @(posedge clk) begin
      if (!i_reset && o_tvalid && i_tready) begin
         if (exp_detect.size() == 0) begin
            $display("output at %0d ns has no matching input sample", $time);
            errors++;
         end else begin
            check_value("detect", longint'(o_detect), longint'(exp_detect[0]));
            check_value("tlast", longint'(o_tlast), longint'(exp_last[0]));
            if (exp_timed[0]) begin
               check_value("latency in ns", longint'($time - exp_time[0]), LATENCY_NS);
            end
            if (exp_zero[0]) begin
               check_value("detect on zero input", longint'(o_detect), 0);
            end
            if (exp_pre[0] && o_detect) begin
               pre_hits++;
            end
            outputs_seen++;
            void'(exp_detect.pop_front());
            void'(exp_last.pop_front());
            void'(exp_time.pop_front());
            void'(exp_timed.pop_front());
            void'(exp_zero.pop_front());
            void'(exp_pre.pop_front());
         end
      end
   end

   initial begin
      int s;
      int errors_before;
      clk = 1'b0;
      i_reset = 1'b1;
      i_clear = 1'b0;
      i_i = '0;
      i_q = '0;
      i_tlast = 1'b0;
      i_tvalid = 1'b0;
      i_tready = 1'b1;
      cur_bp = 1'b0;
      timed_out = 1'b0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      reset_model();
      repeat (8) @(posedge clk);
      i_reset <= 1'b0;
      @(posedge clk);
      check_value("o_tready after reset", longint'(o_tready), 1);
      check_value("o_tvalid after reset", longint'(o_tvalid), 0);
      for (s = 0; s < NUM_SEGS; s++) begin
         if (!timed_out) begin
            errors_before = errors;
            run_segment(s);
            if (timed_out) begin
               tests_failed++;
               $display("test %0d, %s: stopped, no %s within %0d cycles",
                        s, seg_name[s], timeout_what, WAIT_LIMIT);
            end else if (errors == errors_before) begin
               tests_passed++;
               $display("test %0d, %s: passed, %0d outputs checked",
                        s, seg_name[s], outputs_seen);
            end else begin
               tests_failed++;
               $display("test %0d, %s: failed with %0d errors",
                        s, seg_name[s], errors - errors_before);
            end
         end
      end
      $display("tests passed %0d, tests failed %0d, errors %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
source/sc_pkg.sv
source/sc_front_end.sv
source/sc_moving_sum.sv
source/sc_threshold.sv
source/schmidl_cox.sv
tb/tb_schmidl_cox.sv

/* Makefile */
# Verilator build for the Schmidl-Cox detector
# every variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TB_TOP     ?= tb_schmidl_cox
RTL_TOP    ?= schmidl_cox
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing -Wno-fatal

RTL_SRCS = source/sc_pkg.sv \
           source/sc_front_end.sv \
           source/sc_moving_sum.sv \
           source/sc_threshold.sv \
           source/schmidl_cox.sv
TB_SRCS  = tb/tb_schmidl_cox.sv
SIM_BIN  = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(RTL_SRCS) $(TB_SRCS) $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
